// File: verilog/stream_pkg.sv
package stream_pkg;

    // column chain
    localparam int NUM_COLS = 4;
    localparam int COL_W = 2;

    // beat layout, four tkeep bits per lane
    localparam int LANES = 4;
    localparam int ELEM_W = 32;
    localparam int BEAT_W = LANES * ELEM_W;
    localparam int KEEP_W = BEAT_W / 8;

    // per-column register file
    localparam int RF_DEPTH = 32;
    localparam int RF_ADDR_W = 5;
    localparam int LEN_W = 6;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_CNT_W = 5;

    // operand read to writeback and forward
    localparam int MAC_LATENCY = 2;

    localparam logic [1:0] OP_VLOAD = 2'd0;
    localparam logic [1:0] OP_VMACC = 2'd1;
    localparam logic [1:0] OP_VSTREAMOUT = 2'd2;

    localparam int INSTR_W = 24;

    typedef struct packed {
        logic [1:0]                                   opcode;
        logic [RF_ADDR_W-1:0]                         vd;
        logic [RF_ADDR_W-1:0]                         vs;
        logic [LEN_W-1:0]                             len;
        logic [INSTR_W-2-2*RF_ADDR_W-LEN_W-1:0]       pad;
    } arith_fmt_t;

    // load and streamout
    typedef struct packed {
        logic [1:0]                                   opcode;
        logic [COL_W-1:0]                             col;
        logic [RF_ADDR_W-1:0]                         base;
        logic [LEN_W-1:0]                             len;
        logic [INSTR_W-2-COL_W-RF_ADDR_W-LEN_W-1:0]   pad;
    } stream_fmt_t;

    typedef union packed {
        arith_fmt_t  arith_fmt;
        stream_fmt_t stream_fmt;
    } instr_t;

endpackage

// File: verilog/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_push,
    input  logic                              i_pop,
    input  logic [stream_pkg::BEAT_W:0]       i_din,
    output logic [stream_pkg::BEAT_W:0]       o_dout,
    output logic                              o_full,
    output logic                              o_empty,
    output logic [stream_pkg::FIFO_CNT_W-1:0] o_count
);
    import stream_pkg::*;

    logic [BEAT_W:0]       mem [FIFO_DEPTH];
    logic [FIFO_CNT_W-2:0] wr_ptr;
    logic [FIFO_CNT_W-2:0] rd_ptr;
    logic [FIFO_CNT_W-2:0] rd_next;
    logic                  push_ok;
    logic                  pop_ok;

    assign rd_next = rd_ptr + 1'b1;
    assign o_full = (o_count == FIFO_CNT_W'(FIFO_DEPTH));
    assign o_empty = (o_count == '0);
    assign push_ok = i_push && !o_full;
    assign pop_ok = i_pop && !o_empty;

    // o_dout always holds the head entry
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= i_din;
        end
        if (push_ok && (o_empty || (pop_ok && o_count == FIFO_CNT_W'(1)))) begin
            o_dout <= i_din;
        end else if (pop_ok) begin
            o_dout <= mem[rd_next];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            o_count <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_next;
            end
            o_count <= o_count + FIFO_CNT_W'(push_ok) - FIFO_CNT_W'(pop_ok);
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) i_push |-> !o_full)
        else $error("push into full FIFO");
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) i_pop |-> !o_empty)
        else $error("pop from empty FIFO");

endmodule

// File: verilog/vector_regfile.sv
`timescale 1ns/100ps

module vector_regfile (
    input  logic                             clk,
    input  logic                             i_wen,
    input  logic [stream_pkg::RF_ADDR_W-1:0] i_waddr,
    input  logic [stream_pkg::BEAT_W-1:0]    i_wdata,
    input  logic [stream_pkg::RF_ADDR_W-1:0] i_raddr_a,
    input  logic [stream_pkg::RF_ADDR_W-1:0] i_raddr_b,
    output logic [stream_pkg::BEAT_W-1:0]    o_rdata_a,
    output logic [stream_pkg::BEAT_W-1:0]    o_rdata_b
);
    import stream_pkg::*;

    logic [BEAT_W-1:0] mem [RF_DEPTH];

    always_ff @(posedge clk) begin
        if (i_wen) begin
            mem[i_waddr] <= i_wdata;
        end
        // same-cycle read of the write address returns the old beat
        o_rdata_a <= mem[i_raddr_a];
        o_rdata_b <= mem[i_raddr_b];
    end

endmodule

// File: verilog/mac_column.sv
`timescale 1ns/100ps

module mac_column (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_ld_en,
    input  logic [stream_pkg::RF_ADDR_W-1:0] i_ld_addr,
    input  logic [stream_pkg::BEAT_W-1:0]    i_ld_data,
    input  logic                             i_mac_en,
    input  logic [stream_pkg::BEAT_W-1:0]    i_mac_x,
    input  logic [stream_pkg::RF_ADDR_W-1:0] i_vd,
    input  logic [stream_pkg::RF_ADDR_W-1:0] i_vs,
    input  logic [stream_pkg::RF_ADDR_W-1:0] i_k,
    input  logic                             i_rd_en,
    input  logic [stream_pkg::RF_ADDR_W-1:0] i_rd_addr,
    output logic                             o_mac_en,
    output logic [stream_pkg::BEAT_W-1:0]    o_mac_x,
    output logic [stream_pkg::RF_ADDR_W-1:0] o_vd,
    output logic [stream_pkg::RF_ADDR_W-1:0] o_vs,
    output logic [stream_pkg::RF_ADDR_W-1:0] o_k,
    output logic [stream_pkg::BEAT_W-1:0]    o_rd_data
);
    import stream_pkg::*;

    logic                   ld_q;
    logic [RF_ADDR_W-1:0]   ld_addr_q;
    logic [BEAT_W-1:0]      in_q;
    logic [MAC_LATENCY-1:0] en_pipe;
    logic [RF_ADDR_W-1:0]   vd_pipe [MAC_LATENCY];
    logic [RF_ADDR_W-1:0]   vs_pipe [MAC_LATENCY];
    logic [RF_ADDR_W-1:0]   k_pipe [MAC_LATENCY];
    logic [RF_ADDR_W-1:0]   raddr_a;
    logic [BEAT_W-1:0]      rdata_a;
    logic [BEAT_W-1:0]      rdata_b;
    logic [BEAT_W-1:0]      sum;
    logic [BEAT_W-1:0]      sum_q;

    // port a serves streamout reads and the weight, port b the accumulator
    assign raddr_a = i_rd_en ? i_rd_addr : i_vs + i_k;

    vector_regfile rf (
        .clk       (clk),
        .i_wen     (ld_q | en_pipe[MAC_LATENCY-1]),
        .i_waddr   (ld_q ? ld_addr_q : vd_pipe[MAC_LATENCY-1] + k_pipe[MAC_LATENCY-1]),
        .i_wdata   (ld_q ? in_q : sum_q),
        .i_raddr_a (raddr_a),
        .i_raddr_b (i_vd + i_k),
        .o_rdata_a (rdata_a),
        .o_rdata_b (rdata_b)
    );

    // lanewise x*w + acc, wraps at 32 bits
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            sum[l*ELEM_W +: ELEM_W] = in_q[l*ELEM_W +: ELEM_W] * rdata_a[l*ELEM_W +: ELEM_W]
                                    + rdata_b[l*ELEM_W +: ELEM_W];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ld_q <= 1'b0;
            en_pipe <= '0;
        end else begin
            ld_q <= i_ld_en;
            en_pipe <= {en_pipe[MAC_LATENCY-2:0], i_mac_en};
        end
    end

    always_ff @(posedge clk) begin
        ld_addr_q <= i_ld_addr;
        // load beat or x, lined up with the rf read data
        in_q <= i_ld_en ? i_ld_data : i_mac_x;
        sum_q <= sum;
        vd_pipe[0] <= i_vd;
        vs_pipe[0] <= i_vs;
        k_pipe[0] <= i_k;
        for (int s = 1; s < MAC_LATENCY; s++) begin
            vd_pipe[s] <= vd_pipe[s-1];
            vs_pipe[s] <= vs_pipe[s-1];
            k_pipe[s] <= k_pipe[s-1];
        end
    end

    assign o_mac_en = en_pipe[MAC_LATENCY-1];
    assign o_mac_x = sum_q;
    assign o_vd = vd_pipe[MAC_LATENCY-1];
    assign o_vs = vs_pipe[MAC_LATENCY-1];
    assign o_k = k_pipe[MAC_LATENCY-1];
    assign o_rd_data = rdata_a;

    a_single_writer: assert property (@(posedge clk) disable iff (rst)
        !(ld_q && en_pipe[MAC_LATENCY-1]))
        else $error("load and MAC writeback in the same cycle");

endmodule

// File: verilog/command_sequencer.sv
`timescale 1ns/100ps

module command_sequencer (
    input  logic                             clk,
    input  logic                             rst,
    input  stream_pkg::instr_t               i_instr,
    input  logic                             i_instr_valid,
    input  logic                             i_fifo_empty,
    output logic                             o_fifo_pop,
    output logic [stream_pkg::NUM_COLS-1:0]  o_ld_en,
    output logic [stream_pkg::RF_ADDR_W-1:0] o_ld_addr,
    output logic                             o_mac_en,
    output logic [stream_pkg::RF_ADDR_W-1:0] o_vd,
    output logic [stream_pkg::RF_ADDR_W-1:0] o_vs,
    output logic [stream_pkg::RF_ADDR_W-1:0] o_k,
    input  logic                             i_mac_last_done,
    output logic                             o_so_start,
    output logic [stream_pkg::RF_ADDR_W-1:0] o_so_base,
    output logic [stream_pkg::LEN_W-1:0]     o_so_len,
    input  logic                             i_so_done,
    output logic                             o_busy,
    output logic                             o_done
);
    import stream_pkg::*;

    instr_t           cmd;
    logic [1:0]       op;
    logic [LEN_W-1:0] len;
    logic [LEN_W-1:0] issue_cnt;
    logic [LEN_W-1:0] done_cnt;
    logic             accept;
    logic             issue;
    logic             ld_last_q;
    logic             ld_fin_q;
    logic             mac_fin_q;

    // commands arriving while busy are dropped
    assign accept = i_instr_valid && !o_busy;

    // opcode sits at the top of both formats
    assign op = cmd.arith_fmt.opcode;
    assign len = (op == OP_VMACC) ? cmd.arith_fmt.len : cmd.stream_fmt.len;

    // one element per cycle while input beats are waiting
    assign issue = o_busy && (op == OP_VLOAD || op == OP_VMACC)
                   && (issue_cnt != len) && !i_fifo_empty;

    assign o_fifo_pop = issue;
    assign o_ld_en = (issue && op == OP_VLOAD)
                     ? {{(NUM_COLS-1){1'b0}}, 1'b1} << cmd.stream_fmt.col : '0;
    assign o_ld_addr = cmd.stream_fmt.base + issue_cnt[RF_ADDR_W-1:0];
    assign o_mac_en = issue && (op == OP_VMACC);
    assign o_vd = cmd.arith_fmt.vd;
    assign o_vs = cmd.arith_fmt.vs;
    assign o_k = issue_cnt[RF_ADDR_W-1:0];
    assign o_so_base = cmd.stream_fmt.base;
    assign o_so_len = cmd.stream_fmt.len;

    assign o_done = ld_fin_q | mac_fin_q | i_so_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd <= '0;
            o_busy <= 1'b0;
            issue_cnt <= '0;
            done_cnt <= '0;
            o_so_start <= 1'b0;
            ld_last_q <= 1'b0;
            ld_fin_q <= 1'b0;
            mac_fin_q <= 1'b0;
        end else begin
            o_so_start <= accept && (i_instr.stream_fmt.opcode == OP_VSTREAMOUT);
            // last load write lands one cycle after its pop
            ld_last_q <= issue && (op == OP_VLOAD) && (issue_cnt == len - 1'b1);
            ld_fin_q <= ld_last_q;
            mac_fin_q <= i_mac_last_done && (done_cnt == len - 1'b1);
            if (accept) begin
                cmd <= i_instr;
                o_busy <= 1'b1;
                issue_cnt <= '0;
                done_cnt <= '0;
            end else begin
                if (o_done) begin
                    o_busy <= 1'b0;
                end
                if (issue) begin
                    issue_cnt <= issue_cnt + 1'b1;
                end
                if (i_mac_last_done) begin
                    done_cnt <= done_cnt + 1'b1;
                end
            end
        end
    end

    a_so_done_owned: assert property (@(posedge clk) disable iff (rst)
        i_so_done |-> o_busy && op == OP_VSTREAMOUT)
        else $error("streamout done without a streamout command");

endmodule

// File: verilog/streamout_selector.sv
`timescale 1ns/100ps

module streamout_selector (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               i_so_start,
    input  logic [stream_pkg::RF_ADDR_W-1:0]                   i_so_base,
    input  logic [stream_pkg::LEN_W-1:0]                       i_so_len,
    input  logic [stream_pkg::FIFO_CNT_W-1:0]                  i_fifo_count,
    output logic [stream_pkg::NUM_COLS-1:0]                    o_rd_en,
    output logic [stream_pkg::RF_ADDR_W-1:0]                   o_rd_addr,
    input  logic [stream_pkg::NUM_COLS*stream_pkg::BEAT_W-1:0] i_rd_data,
    output logic                                               o_push,
    output logic [stream_pkg::BEAT_W-1:0]                      o_push_data,
    output logic                                               o_push_last,
    output logic                                               o_so_done
);
    import stream_pkg::*;

    logic                 active;
    logic [NUM_COLS-1:0]  supplier;
    logic [NUM_COLS-1:0]  pend_sel;
    logic [RF_ADDR_W-1:0] base;
    logic [LEN_W-1:0]     len;
    logic [LEN_W-1:0]     beat_cnt;
    logic                 issue;
    logic                 col_last;

    // fill count plus the beat pushed this cycle must leave a free slot
    assign issue = active
                   && ((i_fifo_count + FIFO_CNT_W'(o_push)) < FIFO_CNT_W'(FIFO_DEPTH));
    assign col_last = (beat_cnt == len - 1'b1);
    assign o_rd_en = issue ? supplier : '0;
    assign o_rd_addr = base + beat_cnt[RF_ADDR_W-1:0];
    assign o_so_done = o_push && o_push_last;

    // read data of the column that was read last cycle
    always_comb begin
        o_push_data = '0;
        for (int j = 0; j < NUM_COLS; j++) begin
            if (pend_sel[j]) begin
                o_push_data = i_rd_data[j*BEAT_W +: BEAT_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            supplier <= '0;
            beat_cnt <= '0;
            o_push <= 1'b0;
            o_push_last <= 1'b0;
        end else begin
            o_push <= issue;
            o_push_last <= issue && col_last && supplier[NUM_COLS-1];
            if (i_so_start) begin
                active <= 1'b1;
                supplier <= {{(NUM_COLS-1){1'b0}}, 1'b1};
                beat_cnt <= '0;
            end else if (issue && col_last) begin
                beat_cnt <= '0;
                supplier <= supplier << 1;
                active <= !supplier[NUM_COLS-1];
            end else if (issue) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        pend_sel <= supplier;
        if (i_so_start) begin
            base <= i_so_base;
            len <= i_so_len;
        end
    end

    a_supplier_onehot: assert property (@(posedge clk) disable iff (rst)
        active |-> $onehot(supplier))
        else $error("streamout supplier not one-hot");

endmodule

// File: verilog/stream_datapath.sv
`timescale 1ns/100ps

module stream_datapath (
    input  logic                          clk,
    input  logic                          rst,
    input  stream_pkg::instr_t            i_instr,
    input  logic                          i_instr_valid,
    output logic                          o_busy,
    output logic                          o_done,
    input  logic [stream_pkg::BEAT_W-1:0] i_tdata,
    input  logic                          i_tvalid,
    input  logic [stream_pkg::KEEP_W-1:0] i_tkeep,
    output logic                          o_tready,
    output logic [stream_pkg::BEAT_W-1:0] o_tdata,
    output logic                          o_tvalid,
    output logic [stream_pkg::KEEP_W-1:0] o_tkeep,
    output logic                          o_tlast,
    input  logic                          i_tready
);
    import stream_pkg::*;

    logic [BEAT_W-1:0]          masked_data;
    logic [BEAT_W:0]            in_dout;
    logic                       in_full;
    logic                       in_empty;
    logic                       in_pop;
    logic                       out_empty;
    logic [FIFO_CNT_W-1:0]      out_count;
    logic [NUM_COLS-1:0]        ld_en;
    logic [RF_ADDR_W-1:0]       ld_addr;
    logic                       so_start;
    logic [RF_ADDR_W-1:0]       so_base;
    logic [LEN_W-1:0]           so_len;
    logic                       so_done;
    logic [NUM_COLS-1:0]        rd_en;
    logic [RF_ADDR_W-1:0]       rd_addr;
    logic [NUM_COLS*BEAT_W-1:0] rd_data_all;
    logic                       push;
    logic                       push_last;
    logic [BEAT_W-1:0]          push_data;
    // MAC chain, entry NUM_COLS is the tail
    logic [NUM_COLS:0]          mac_en;
    logic [BEAT_W-1:0]          mac_x [NUM_COLS+1];
    logic [RF_ADDR_W-1:0]       vd [NUM_COLS+1];
    logic [RF_ADDR_W-1:0]       vs [NUM_COLS+1];
    logic [RF_ADDR_W-1:0]       k [NUM_COLS+1];

    // partly kept lanes enter as zero
    for (genvar l = 0; l < LANES; l++) begin : g_lane
        assign masked_data[l*ELEM_W +: ELEM_W] =
            (&i_tkeep[l*(ELEM_W/8) +: ELEM_W/8]) ? i_tdata[l*ELEM_W +: ELEM_W] : '0;
    end

    assign o_tready = !in_full;
    assign o_tvalid = !out_empty;
    assign o_tkeep = {KEEP_W{!out_empty}};
    assign mac_x[0] = in_dout[BEAT_W-1:0];

    sync_fifo in_fifo (
        .clk(clk), .rst(rst),
        .i_push(i_tvalid && !in_full), .i_pop(in_pop), .i_din({1'b0, masked_data}),
        .o_dout(in_dout), .o_full(in_full), .o_empty(in_empty), .o_count()
    );

    command_sequencer seq (
        .clk(clk), .rst(rst),
        .i_instr(i_instr), .i_instr_valid(i_instr_valid),
        .i_fifo_empty(in_empty), .o_fifo_pop(in_pop),
        .o_ld_en(ld_en), .o_ld_addr(ld_addr),
        .o_mac_en(mac_en[0]), .o_vd(vd[0]), .o_vs(vs[0]), .o_k(k[0]),
        .i_mac_last_done(mac_en[NUM_COLS]),
        .o_so_start(so_start), .o_so_base(so_base), .o_so_len(so_len), .i_so_done(so_done),
        .o_busy(o_busy), .o_done(o_done)
    );

    for (genvar j = 0; j < NUM_COLS; j++) begin : g_col
        mac_column col (
            .clk(clk), .rst(rst),
            .i_ld_en(ld_en[j]), .i_ld_addr(ld_addr), .i_ld_data(in_dout[BEAT_W-1:0]),
            .i_mac_en(mac_en[j]), .i_mac_x(mac_x[j]),
            .i_vd(vd[j]), .i_vs(vs[j]), .i_k(k[j]),
            .i_rd_en(rd_en[j]), .i_rd_addr(rd_addr),
            .o_mac_en(mac_en[j+1]), .o_mac_x(mac_x[j+1]),
            .o_vd(vd[j+1]), .o_vs(vs[j+1]), .o_k(k[j+1]),
            .o_rd_data(rd_data_all[j*BEAT_W +: BEAT_W])
        );
    end

    streamout_selector sel (
        .clk(clk), .rst(rst),
        .i_so_start(so_start), .i_so_base(so_base), .i_so_len(so_len),
        .i_fifo_count(out_count),
        .o_rd_en(rd_en), .o_rd_addr(rd_addr), .i_rd_data(rd_data_all),
        .o_push(push), .o_push_data(push_data), .o_push_last(push_last),
        .o_so_done(so_done)
    );

    sync_fifo out_fifo (
        .clk(clk), .rst(rst),
        .i_push(push), .i_pop(i_tready && !out_empty), .i_din({push_last, push_data}),
        .o_dout({o_tlast, o_tdata}), .o_full(), .o_empty(out_empty), .o_count(out_count)
    );

endmodule

// File: include/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// shadow copy of every column's register file
logic [BEAT_W-1:0] shadow [NUM_COLS][RF_DEPTH];

// input beats still to send, output beats as taken
logic [BEAT_W-1:0] tx_data [$];
logic [KEEP_W-1:0] tx_keep [$];
logic [BEAT_W-1:0] rx_data [$];
logic [KEEP_W-1:0] rx_keep [$];
logic              rx_last [$];

int error_count = 0;
int check_count = 0;
bit backpressure = 1'b0;

task automatic check(input string name, input logic [BEAT_W-1:0] got,
                     input logic [BEAT_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERROR: %s = %h, expected %h", name, got, exp);
    end
endtask

// a lane survives only when all four of its keep bits are set
function automatic logic [BEAT_W-1:0] kept(input logic [BEAT_W-1:0] d,
                                           input logic [KEEP_W-1:0] keep);
    logic [BEAT_W-1:0] r;
    r = '0;
    for (int l = 0; l < LANES; l++) begin
        if (keep[l*4 +: 4] == 4'hf) begin
            r[l*ELEM_W +: ELEM_W] = d[l*ELEM_W +: ELEM_W];
        end
    end
    return r;
endfunction

task automatic model_load(input int col, input int base);
    for (int k = 0; k < tx_data.size(); k++) begin
        shadow[col][(base + k) % RF_DEPTH] = kept(tx_data[k], tx_keep[k]);
    end
endtask

// each column does acc += x * w per lane and hands the sum on as the next x
task automatic model_mac(input int vd, input int vs);
    logic [BEAT_W-1:0] x;
    logic [ELEM_W-1:0] w;
    logic [ELEM_W-1:0] acc;
    int                d;
    for (int k = 0; k < tx_data.size(); k++) begin
        x = kept(tx_data[k], tx_keep[k]);
        d = (vd + k) % RF_DEPTH;
        for (int j = 0; j < NUM_COLS; j++) begin
            for (int l = 0; l < LANES; l++) begin
                w = shadow[j][(vs + k) % RF_DEPTH][l*ELEM_W +: ELEM_W];
                acc = shadow[j][d][l*ELEM_W +: ELEM_W];
                x[l*ELEM_W +: ELEM_W] = x[l*ELEM_W +: ELEM_W] * w + acc;
            end
            shadow[j][d] = x;
        end
    end
endtask

// input stream driver, empties the tx queues
task automatic send_beats();
    bit taken;
    while (tx_data.size() > 0) begin
        @(posedge clk);
        i_tvalid <= 1'b1;
        i_tdata <= tx_data[0];
        i_tkeep <= tx_keep[0];
        @(negedge clk);
        taken = o_tready;
        if (taken) begin
            void'(tx_data.pop_front());
            void'(tx_keep.pop_front());
        end
    end
    @(posedge clk);
    i_tvalid <= 1'b0;
endtask

// output stream receiver, ready toggles at random under back-pressure
task automatic receive_beats(input int n);
    while (rx_data.size() < n) begin
        @(posedge clk);
        i_tready <= backpressure ? 1'($random(seed)) : 1'b1;
        @(negedge clk);
        if (o_tvalid && i_tready) begin
            rx_data.push_back(o_tdata);
            rx_keep.push_back(o_tkeep);
            rx_last.push_back(o_tlast);
        end
    end
    @(posedge clk);
    i_tready <= 1'b0;
endtask

`endif

// File: tests/tb_stream_datapath.sv
`timescale 1ns/100ps

module tb_stream_datapath;
    import stream_pkg::*;

    // five tests of up to four columns of 32 beats with 32 cycles of slack per beat
    localparam int TIMEOUT_CYCLES = 5 * NUM_COLS * RF_DEPTH * 32;

    logic               clk;
    logic               rst;
    logic [INSTR_W-1:0] i_instr;
    logic               i_instr_valid;
    logic               o_busy;
    logic               o_done;
    logic [BEAT_W-1:0]  i_tdata;
    logic               i_tvalid;
    logic [KEEP_W-1:0]  i_tkeep;
    logic               o_tready;
    logic [BEAT_W-1:0]  o_tdata;
    logic               o_tvalid;
    logic [KEEP_W-1:0]  o_tkeep;
    logic               o_tlast;
    logic               i_tready;
    integer             seed = 32'h010d_b1cb;
    int                 cycle_cnt = 0;
    int                 done_seen = 0;
    int                 tests_run = 0;

    `include "tb_model.svh"

    stream_datapath dut0 (
        .clk(clk), .rst(rst),
        .i_instr(i_instr), .i_instr_valid(i_instr_valid),
        .o_busy(o_busy), .o_done(o_done),
        .i_tdata(i_tdata), .i_tvalid(i_tvalid), .i_tkeep(i_tkeep), .o_tready(o_tready),
        .o_tdata(o_tdata), .o_tvalid(o_tvalid), .o_tkeep(o_tkeep), .o_tlast(o_tlast),
        .i_tready(i_tready)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!rst && o_done) begin
            done_seen <= done_seen + 1;
        end
    end

    function automatic logic [INSTR_W-1:0] stream_cmd(input logic [1:0] op, input int col,
                                                      input int base, input int len);
        return {op, COL_W'(col), RF_ADDR_W'(base), LEN_W'(len), 9'd0};
    endfunction

    function automatic logic [INSTR_W-1:0] arith_cmd(input int vd, input int vs, input int len);
        return {OP_VMACC, RF_ADDR_W'(vd), RF_ADDR_W'(vs), LEN_W'(len), 6'd0};
    endfunction

    task automatic issue_cmd(input logic [INSTR_W-1:0] cmd);
        @(posedge clk);
        i_instr <= cmd;
        i_instr_valid <= 1'b1;
        @(posedge clk);
        i_instr_valid <= 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!o_done) begin
            @(negedge clk);
        end
    endtask

    task automatic queue_random(input int n);
        for (int i = 0; i < n; i++) begin
            tx_data.push_back({$random(seed), $random(seed), $random(seed), $random(seed)});
            tx_keep.push_back({KEEP_W{1'b1}});
        end
    endtask

    // command that eats the queued input beats
    task automatic run_input_cmd(input logic [INSTR_W-1:0] cmd);
        fork
            begin
                issue_cmd(cmd);
                wait_done();
            end
            send_beats();
        join
    endtask

    task automatic load_random(input int col, input int base, input int n);
        queue_random(n);
        model_load(col, base);
        run_input_cmd(stream_cmd(OP_VLOAD, col, base, n));
    endtask

    task automatic stream_out(input int base, input int len);
        int n;
        fork
            begin
                issue_cmd(stream_cmd(OP_VSTREAMOUT, 0, base, len));
                wait_done();
            end
            receive_beats(NUM_COLS * len);
        join
        @(negedge clk);
        check("o_tvalid", BEAT_W'(o_tvalid), '0);
        n = 0;
        // columns supply in order and tlast marks only the very last beat
        for (int j = 0; j < NUM_COLS; j++) begin
            for (int b = 0; b < len; b++) begin
                check("o_tdata", rx_data[n], shadow[j][(base + b) % RF_DEPTH]);
                check("o_tkeep", BEAT_W'(rx_keep[n]), BEAT_W'({KEEP_W{1'b1}}));
                check("o_tlast", BEAT_W'(rx_last[n]),
                      BEAT_W'(j == NUM_COLS - 1 && b == len - 1));
                n++;
            end
        end
        rx_data.delete();
        rx_keep.delete();
        rx_last.delete();
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        $display("test %s finished, %0d errors", name, error_count - errs_before);
    endtask

    task automatic test_reset();
        int errs;
        errs = error_count;
        check("o_busy", BEAT_W'(o_busy), '0);
        check("o_done", BEAT_W'(o_done), '0);
        check("o_tvalid", BEAT_W'(o_tvalid), '0);
        check("o_tready", BEAT_W'(o_tready), BEAT_W'(1'b1));
        end_test("reset_state", errs);
    endtask

    task automatic test_load_stream();
        int errs;
        int dones;
        errs = error_count;
        dones = done_seen;
        for (int j = 0; j < NUM_COLS; j++) begin
            load_random(j, 3, 8);
        end
        stream_out(3, 8);
        check("o_done count", BEAT_W'(done_seen - dones), BEAT_W'(NUM_COLS + 1));
        end_test("load_streamout", errs);
    endtask

    task automatic test_mac();
        int errs;
        errs = error_count;
        // weights at 0 and accumulators at 16 so elements never overlap
        for (int j = 0; j < NUM_COLS; j++) begin
            load_random(j, 0, 8);
            load_random(j, 16, 8);
        end
        queue_random(8);
        model_mac(16, 0);
        run_input_cmd(arith_cmd(16, 0, 8));
        stream_out(16, 8);
        end_test("mac_chain", errs);
    endtask

    task automatic test_backpressure();
        int errs;
        errs = error_count;
        for (int j = 0; j < NUM_COLS; j++) begin
            load_random(j, 0, RF_DEPTH);
        end
        backpressure = 1'b1;
        stream_out(0, RF_DEPTH);
        backpressure = 1'b0;
        end_test("backpressure", errs);
    endtask

    task automatic test_keep_ignore();
        int errs;
        errs = error_count;
        queue_random(4);
        // lane 2 of the second beat misses one byte
        tx_keep[1] = 16'hf7ff;
        model_load(1, 4);
        issue_cmd(stream_cmd(OP_VLOAD, 1, 4, 4));
        @(negedge clk);
        check("o_busy", BEAT_W'(o_busy), BEAT_W'(1'b1));
        // strobed while busy so column 2 keeps its old beats
        issue_cmd(stream_cmd(OP_VLOAD, 2, 4, 4));
        fork
            wait_done();
            send_beats();
        join
        stream_out(4, 4);
        end_test("keep_and_ignored_cmd", errs);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        i_instr = '0;
        i_instr_valid = 1'b0;
        i_tdata = '0;
        i_tvalid = 1'b0;
        i_tkeep = '0;
        i_tready = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_reset();
        test_load_stream();
        test_mac();
        test_backpressure();
        test_keep_ignore();
        $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
verilog/stream_pkg.sv
verilog/sync_fifo.sv
verilog/vector_regfile.sv
verilog/mac_column.sv
verilog/command_sequencer.sv
verilog/streamout_selector.sv
verilog/stream_datapath.sv
tests/tb_stream_datapath.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_stream_datapath \
    -f sim.f > build.log 2>&1 &&
    ./obj_dir/Vtb_stream_datapath > sim.log 2>&1 ||
    echo "build or simulation did not complete, see build.log and sim.log"

grep -qx "Test OK" sim.log 2>/dev/null && echo "PASS" || {
    echo "FAIL, see sim.log"
    exit 1
}
